// File: Makefile
TOP = tb_sdram_ctrl

.PHONY: sim clean

sim:
	verilator --binary --assert --timing -f src.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

// File: hw/sdram_cmd_fifo.sv
// Command queue between the host front end and the SDRAM sequencer.
// Circular buffer with a combinational head; a pushed word shows at the head
// on the next cycle. Every pop returns one credit to the front end a cycle later.
// The host credits keep it from overflowing, so it has no full flag.
`include "sdram_config.svh"

module sdram_cmd_fifo (
    input  logic                  hclk,
    input  logic                  nrst,
    input  logic                  push_i,
    input  sdram_pkg::sdram_req_t push_data_i,
    input  logic                  pop_i,
    output logic                  not_empty_o,
    output sdram_pkg::sdram_req_t head_o,
    output logic                  credit_return_o
);
    import sdram_pkg::*;

    localparam int DEPTH = `SDRAM_CMD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    sdram_req_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             credit_q;

    assign not_empty_o     = (count_q != '0);
    assign head_o          = mem_q[rd_ptr_q];
    assign credit_return_o = credit_q;

    always_ff @(posedge hclk)
    begin
        if (push_i)
            mem_q[wr_ptr_q] <= push_data_i;
    end

    always_ff @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end
        else
        begin
            credit_q <= pop_i;          // One credit per entry taken
            if (push_i)
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push_i && !pop_i)
                count_q <= count_q + 1'b1;
            else if (pop_i && !push_i)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: hw/sdram_config.svh
// Timing counts, mode register fields and queue sizing for the SDRAM controller.
// Include this in any file that needs a width, a wait length or the mode word.
// All counts are in controller clock cycles.
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// Pin widths
`define SDRAM_ADDR_W            12
`define SDRAM_BA_W              2

// Queue entries, equal to the number of host credits
`define SDRAM_CMD_FIFO_DEPTH    4

// Power-up and command spacing
`define SDRAM_INIT_WAIT         2500
`define SDRAM_TRP               2
`define SDRAM_TRFC              3
`define SDRAM_TMRD              2
`define SDRAM_REFRESH_INTERVAL  750
`define SDRAM_BURST_WAIT        8

// Mode register fields, together 12'h213
`define SDRAM_MODE_BURST_LEN    3'b011
`define SDRAM_MODE_BURST_TYPE   1'b0
`define SDRAM_MODE_CAS_LAT      3'b001
`define SDRAM_MODE_OP           2'b00
`define SDRAM_MODE_WRITE_BURST  1'b1

`endif

// File: hw/sdram_ctrl_top.sv
// Top level of the SDRAM command controller.
// Host requests pass through the front end into the command queue, and the
// sequencer drains the queue onto the SDRAM pins. Credits flow back from the
// queue to the front end, one per request taken by the sequencer.
`include "sdram_config.svh"

module sdram_ctrl_top (
    input  logic                     hclk,
    input  logic                     nrst,
    input  logic                     req_valid_i,
    input  logic                     req_write_i,
    input  logic [`SDRAM_BA_W-1:0]   req_ba_i,
    input  logic [`SDRAM_ADDR_W-1:0] req_addr_i,
    output logic                     req_ready_o,
    output logic                     mem_cke_o,
    output logic                     mem_cs_n_o,
    output logic                     mem_ras_n_o,
    output logic                     mem_cas_n_o,
    output logic                     mem_we_n_o,
    output logic [`SDRAM_BA_W-1:0]   mem_ba_o,
    output logic [`SDRAM_ADDR_W-1:0] mem_addr_o
);
    import sdram_pkg::*;

    logic       push;
    sdram_req_t push_data;
    logic       pop;
    logic       not_empty;
    sdram_req_t head;
    logic       credit_return;

    sdram_req_frontend u_frontend (
        .hclk            (hclk),
        .nrst            (nrst),
        .req_valid_i     (req_valid_i),
        .req_write_i     (req_write_i),
        .req_ba_i        (req_ba_i),
        .req_addr_i      (req_addr_i),
        .credit_return_i (credit_return),
        .req_ready_o     (req_ready_o),
        .push_o          (push),
        .push_data_o     (push_data)
    );

    sdram_cmd_fifo u_cmd_fifo (
        .hclk            (hclk),
        .nrst            (nrst),
        .push_i          (push),
        .push_data_i     (push_data),
        .pop_i           (pop),
        .not_empty_o     (not_empty),
        .head_o          (head),
        .credit_return_o (credit_return)
    );

    sdram_sequencer u_sequencer (
        .hclk        (hclk),
        .nrst        (nrst),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .mem_cke_o   (mem_cke_o),
        .mem_cs_n_o  (mem_cs_n_o),
        .mem_ras_n_o (mem_ras_n_o),
        .mem_cas_n_o (mem_cas_n_o),
        .mem_we_n_o  (mem_we_n_o),
        .mem_ba_o    (mem_ba_o),
        .mem_addr_o  (mem_addr_o)
    );

endmodule

// File: hw/sdram_pkg.sv
// Shared types of the SDRAM controller: the pin command encoding,
// the two views of the address word and the queued request word.
// Import inside a module body, or use scoped names in port lists.
`include "sdram_config.svh"

package sdram_pkg;

    // {cs_n, ras_n, cas_n, we_n}, all active low
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    // Row/column address, or the mode register word during LOAD_MODE
    typedef union packed {
        logic [`SDRAM_ADDR_W-1:0] raw;
        struct packed {
            logic [1:0] reserved;
            logic       write_burst;    // 1 selects single-location writes
            logic [1:0] op_mode;
            logic [2:0] cas_lat;
            logic       burst_type;     // 0 is sequential
            logic [2:0] burst_len;      // 3'b011 gives eight words
        } mode;
    } sdram_addr_u;

    // One host request as it sits in the queue
    typedef struct packed {
        logic                     is_write;
        logic [`SDRAM_BA_W-1:0]   ba;
        logic [`SDRAM_ADDR_W-1:0] addr;
    } sdram_req_t;

endpackage

// File: hw/sdram_req_frontend.sv
// Host request front end of the SDRAM controller.
// Accepts a request whenever a credit is held and pushes it into the command
// queue in the same cycle. Credits come back from the queue one per pop.
`include "sdram_config.svh"

module sdram_req_frontend (
    input  logic                     hclk,
    input  logic                     nrst,
    input  logic                     req_valid_i,
    input  logic                     req_write_i,
    input  logic [`SDRAM_BA_W-1:0]   req_ba_i,
    input  logic [`SDRAM_ADDR_W-1:0] req_addr_i,
    input  logic                     credit_return_i,
    output logic                     req_ready_o,
    output logic                     push_o,
    output sdram_pkg::sdram_req_t    push_data_o
);

    localparam int CREDIT_W = $clog2(`SDRAM_CMD_FIFO_DEPTH + 1);

    logic [CREDIT_W-1:0] credit_q;      // Free queue entries as seen by the host

    assign req_ready_o = (credit_q != '0);
    assign push_o      = req_valid_i && req_ready_o;     // Accept and push together

    assign push_data_o.is_write = req_write_i;
    assign push_data_o.ba       = req_ba_i;
    assign push_data_o.addr     = req_addr_i;

    // Accept and return in the same cycle cancel out
    always_ff @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
            credit_q <= CREDIT_W'(`SDRAM_CMD_FIFO_DEPTH);
        else if (push_o && !credit_return_i)
            credit_q <= credit_q - 1'b1;
        else if (credit_return_i && !push_o)
            credit_q <= credit_q + 1'b1;
    end

endmodule

// File: hw/sdram_sequencer.sv
// SDRAM command sequencer.
// Runs the power-up sequence, schedules auto-refresh, and turns queued requests
// into ACTIVE / READ or WRITE / PRECHARGE. All pins come from registers, so a
// command decided in one cycle shows on the pins in the next.
// One down-counter times the wait of each phase; a second one schedules refresh.
`include "sdram_config.svh"

module sdram_sequencer (
    input  logic                     hclk,
    input  logic                     nrst,
    input  logic                     not_empty_i,
    input  sdram_pkg::sdram_req_t    head_i,
    output logic                     pop_o,
    output logic                     mem_cke_o,
    output logic                     mem_cs_n_o,
    output logic                     mem_ras_n_o,
    output logic                     mem_cas_n_o,
    output logic                     mem_we_n_o,
    output logic [`SDRAM_BA_W-1:0]   mem_ba_o,
    output logic [`SDRAM_ADDR_W-1:0] mem_addr_o
);
    import sdram_pkg::*;

    localparam int WAIT_W     = $clog2(`SDRAM_INIT_WAIT + 1);
    localparam int REF_W      = $clog2(`SDRAM_REFRESH_INTERVAL + 1);
    localparam int WRITE_WAIT = 2;      // WRITE to PRECHARGE spacing
    localparam int AP_BIT     = 10;     // A10, precharge-all / auto-precharge

    // Init states sit below S_IDLE
    localparam logic [3:0] S_INIT_WAIT = 4'd0;
    localparam logic [3:0] S_INIT_PRE  = 4'd1;
    localparam logic [3:0] S_INIT_REF1 = 4'd2;
    localparam logic [3:0] S_INIT_REF2 = 4'd3;
    localparam logic [3:0] S_LOAD_MODE = 4'd4;
    localparam logic [3:0] S_IDLE      = 4'd5;
    localparam logic [3:0] S_REFRESH   = 4'd6;
    localparam logic [3:0] S_ACTIVATE  = 4'd7;
    localparam logic [3:0] S_READ      = 4'd8;
    localparam logic [3:0] S_WRITE     = 4'd9;
    localparam logic [3:0] S_PRECHARGE = 4'd10;

    logic [3:0]        state_q;
    logic [3:0]        state_d;
    logic [WAIT_W-1:0] cnt_q;
    logic [WAIT_W-1:0] cnt_d;
    logic [REF_W-1:0]  ref_cnt_q;
    logic              ref_due;
    logic              cke_q;
    logic              cke_d;
    sdram_cmd_e        cmd_q;
    sdram_cmd_e        cmd_d;
    sdram_addr_u       addr_q;
    sdram_addr_u       addr_d;
    sdram_req_t        req_q;           // Request being served
    sdram_req_t        req_d;

    assign ref_due = (ref_cnt_q == '0);
    assign pop_o   = (state_q == S_IDLE) && not_empty_i && !ref_due;

    assign mem_cke_o  = cke_q;
    assign {mem_cs_n_o, mem_ras_n_o, mem_cas_n_o, mem_we_n_o} = cmd_q;
    assign mem_ba_o   = req_q.ba;
    assign mem_addr_o = addr_q.raw;

    always_comb
    begin
        state_d = state_q;
        cnt_d   = (cnt_q != '0) ? cnt_q - 1'b1 : '0;
        cke_d   = cke_q;
        cmd_d   = CMD_NOP;
        addr_d  = addr_q;
        req_d   = req_q;
        case (state_q)
            S_INIT_WAIT:
            begin
                if (cnt_q == WAIT_W'(1))
                    cke_d = 1'b1;       // Clock enabled for one NOP before PRECHARGE
                if (cnt_q == '0)
                begin
                    state_d                = S_INIT_PRE;
                    cnt_d                  = WAIT_W'(`SDRAM_TRP - 1);
                    cmd_d                  = CMD_PRECHARGE;
                    addr_d.raw             = '0;
                    addr_d.raw[AP_BIT]     = 1'b1;
                end
            end
            S_INIT_PRE, S_INIT_REF1:
            begin
                if (cnt_q == '0)
                begin
                    state_d = (state_q == S_INIT_PRE) ? S_INIT_REF1 : S_INIT_REF2;
                    cnt_d   = WAIT_W'(`SDRAM_TRFC - 1);
                    cmd_d   = CMD_REFRESH;
                end
            end
            S_INIT_REF2:
            begin
                if (cnt_q == '0)
                begin
                    state_d                 = S_LOAD_MODE;
                    cnt_d                   = WAIT_W'(`SDRAM_TMRD - 1);
                    cmd_d                   = CMD_LOAD_MODE;
                    addr_d.mode.reserved    = '0;
                    addr_d.mode.write_burst = `SDRAM_MODE_WRITE_BURST;
                    addr_d.mode.op_mode     = `SDRAM_MODE_OP;
                    addr_d.mode.cas_lat     = `SDRAM_MODE_CAS_LAT;
                    addr_d.mode.burst_type  = `SDRAM_MODE_BURST_TYPE;
                    addr_d.mode.burst_len   = `SDRAM_MODE_BURST_LEN;
                end
            end
            S_LOAD_MODE, S_PRECHARGE:
            begin
                if (cnt_q == '0)
                    state_d = S_IDLE;
            end
            S_IDLE:
            begin
                if (ref_due)            // Refresh wins over queued requests
                begin
                    state_d            = S_REFRESH;
                    cnt_d              = WAIT_W'(`SDRAM_TRFC + 1);
                    cmd_d              = CMD_PRECHARGE;
                    addr_d.raw         = '0;
                    addr_d.raw[AP_BIT] = 1'b1;
                end
                else if (pop_o)
                begin
                    state_d    = S_ACTIVATE;
                    cmd_d      = CMD_ACTIVE;
                    req_d      = head_i;
                    addr_d.raw = head_i.addr;   // Row address
                end
            end
            S_REFRESH:
            begin
                if (cnt_q == '0)
                    state_d = S_IDLE;
                else if (cnt_q == WAIT_W'(`SDRAM_TRFC + 1))
                    cmd_d = CMD_REFRESH;        // One cycle after the PRECHARGE
            end
            S_ACTIVATE:
            begin
                addr_d.raw         = req_q.addr;
                addr_d.raw[AP_BIT] = 1'b0;      // No auto-precharge, closed explicitly
                if (req_q.is_write)
                begin
                    state_d = S_WRITE;
                    cnt_d   = WAIT_W'(WRITE_WAIT - 1);
                    cmd_d   = CMD_WRITE;
                end
                else
                begin
                    state_d = S_READ;
                    cnt_d   = WAIT_W'(`SDRAM_BURST_WAIT - 1);
                    cmd_d   = CMD_READ;
                end
            end
            S_READ, S_WRITE:
            begin
                if (cnt_q == '0)
                begin
                    state_d = S_PRECHARGE;      // Bank from req_q, A10 still low
                    cnt_d   = WAIT_W'(`SDRAM_TRP - 1);
                    cmd_d   = CMD_PRECHARGE;
                end
            end
            default:
            begin
                state_d = S_INIT_WAIT;
                cnt_d   = WAIT_W'(`SDRAM_INIT_WAIT);
                cke_d   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
        begin
            state_q <= S_INIT_WAIT;
            cnt_q   <= WAIT_W'(`SDRAM_INIT_WAIT);
            cke_q   <= 1'b0;
            cmd_q   <= CMD_NOP;
        end
        else
        begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            cke_q   <= cke_d;
            cmd_q   <= cmd_d;
        end
    end

    always_ff @(posedge hclk)
    begin
        addr_q <= addr_d;
        req_q  <= req_d;
    end

    // Interval restarts at the end of init and of every refresh
    always_ff @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
            ref_cnt_q <= REF_W'(`SDRAM_REFRESH_INTERVAL);
        else if (state_q < S_IDLE || state_q == S_REFRESH)
            ref_cnt_q <= REF_W'(`SDRAM_REFRESH_INTERVAL);
        else if (!ref_due)
            ref_cnt_q <= ref_cnt_q - 1'b1;
    end

endmodule

// File: src.f
+incdir+hw
hw/sdram_pkg.sv
hw/sdram_req_frontend.sv
hw/sdram_cmd_fifo.sv
hw/sdram_sequencer.sv
hw/sdram_ctrl_top.sv
test/sdram_ctrl_assertions.sv
test/tb_sdram_ctrl.sv

// File: test/sdram_ctrl_assertions.sv
// Concurrent checks on the SDRAM pins and on the host credit handshake.
// Bound into the controller top level, it watches the pins, the host port
// and the pop/head signals between the queue and the sequencer.
`include "sdram_config.svh"

module sdram_ctrl_assertions (
    input logic                     hclk,
    input logic                     nrst,
    input logic                     req_valid_i,
    input logic                     req_ready_o,
    input logic                     pop_i,
    input logic [14:0]              head_i,      // {is_write, ba, addr}
    input logic                     mem_cke_o,
    input logic                     mem_cs_n_o,
    input logic                     mem_ras_n_o,
    input logic                     mem_cas_n_o,
    input logic                     mem_we_n_o,
    input logic [`SDRAM_BA_W-1:0]   mem_ba_o,
    input logic [`SDRAM_ADDR_W-1:0] mem_addr_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;

    localparam int BW      = `SDRAM_BURST_WAIT;
    localparam int MAX_GAP = `SDRAM_REFRESH_INTERVAL + `SDRAM_BURST_WAIT + `SDRAM_TRP
                             + `SDRAM_TRFC + 8;     // Refresh may wait for a whole read

    logic [3:0]  cmd;
    logic [11:0] init_cnt;      // Cycles since reset release, saturating
    logic [2:0]  n_cmds;        // Non-NOP commands seen, saturating at four
    logic [11:0] gap_cnt;       // Cycles since the last REFRESH or LOAD_MODE
    logic [2:0]  outstanding;   // Accepted requests without ACTIVE yet

    assign cmd = {mem_cs_n_o, mem_ras_n_o, mem_cas_n_o, mem_we_n_o};

    always_ff @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
        begin
            init_cnt    <= '0;
            n_cmds      <= '0;
            gap_cnt     <= '0;
            outstanding <= '0;
        end
        else
        begin
            if (init_cnt < 12'(`SDRAM_INIT_WAIT))
                init_cnt <= init_cnt + 1'b1;
            if (cmd != CMD_NOP && n_cmds < 3'd4)
                n_cmds <= n_cmds + 1'b1;
            if (cmd == CMD_REFRESH || cmd == CMD_LOAD_MODE)
                gap_cnt <= '0;
            else if (gap_cnt != '1)
                gap_cnt <= gap_cnt + 1'b1;
            outstanding <= outstanding + 3'(req_valid_i && req_ready_o)
                           - 3'(cmd == CMD_ACTIVE);
        end
    end

    a_reset_quiet: assert property (@(posedge hclk)
        !nrst |-> (!mem_cke_o && cmd == CMD_NOP))
        else $error("clock enable or command active during reset");

    a_init_wait: assert property (@(posedge hclk) disable iff (!nrst)
        (init_cnt < 12'(`SDRAM_INIT_WAIT)) |-> (!mem_cke_o && cmd == CMD_NOP))
        else $error("clock enable or command active during init wait");

    a_init_pre: assert property (@(posedge hclk) disable iff (!nrst)
        (cmd != CMD_NOP && n_cmds == 3'd0) |-> cmd == CMD_PRECHARGE)
        else $error("first init command is not PRECHARGE");

    a_init_ref: assert property (@(posedge hclk) disable iff (!nrst)
        (cmd != CMD_NOP && (n_cmds == 3'd1 || n_cmds == 3'd2)) |-> cmd == CMD_REFRESH)
        else $error("init REFRESH missing");

    a_init_mode: assert property (@(posedge hclk) disable iff (!nrst)
        (cmd != CMD_NOP && n_cmds == 3'd3) |-> (cmd == CMD_LOAD_MODE && mem_addr_o == 12'h213))
        else $error("init LOAD_MODE missing or wrong mode word");

    a_read_seq: assert property (@(posedge hclk) disable iff (!nrst)
        (pop_i && !head_i[14]) |=>
            (cmd == CMD_ACTIVE && mem_addr_o == $past(head_i[11:0])
             && mem_ba_o == $past(head_i[13:12]))
            ##1 (cmd == CMD_READ) ##BW (cmd == CMD_PRECHARGE))
        else $error("read sequence out of order");

    a_write_seq: assert property (@(posedge hclk) disable iff (!nrst)
        (pop_i && head_i[14]) |=>
            (cmd == CMD_ACTIVE && mem_addr_o == $past(head_i[11:0])
             && mem_ba_o == $past(head_i[13:12]))
            ##1 (cmd == CMD_WRITE) ##2 (cmd == CMD_PRECHARGE))
        else $error("write sequence out of order");

    a_ref_pre: assert property (@(posedge hclk) disable iff (!nrst)
        (cmd == CMD_REFRESH && n_cmds == 3'd4) |-> $past(cmd) == CMD_PRECHARGE)
        else $error("REFRESH without PRECHARGE before it");

    a_ref_gap: assert property (@(posedge hclk) disable iff (!nrst)
        (n_cmds == 3'd4) |-> gap_cnt <= 12'(MAX_GAP))
        else $error("refresh interval exceeded");

    a_credit: assert property (@(posedge hclk) disable iff (!nrst)
        req_ready_o == (outstanding != 3'(`SDRAM_CMD_FIFO_DEPTH)))
        else $error("req_ready_o does not match requests in flight");

endmodule

bind sdram_ctrl_top sdram_ctrl_assertions u_assertions (
    .hclk        (hclk),
    .nrst        (nrst),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .pop_i       (pop),
    .head_i      (head),
    .mem_cke_o   (mem_cke_o),
    .mem_cs_n_o  (mem_cs_n_o),
    .mem_ras_n_o (mem_ras_n_o),
    .mem_cas_n_o (mem_cas_n_o),
    .mem_we_n_o  (mem_we_n_o),
    .mem_ba_o    (mem_ba_o),
    .mem_addr_o  (mem_addr_o)
);

// File: test/tb_sdram_ctrl.sv
// Testbench for the SDRAM command controller.
// Waits for init, sends twelve pseudo-random reads and writes, then waits for
// two refreshes and all request PRECHARGEs. The bound checker does the checking.
`include "sdram_config.svh"

module tb_sdram_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import sdram_pkg::*;

    localparam int NUM_REQ      = 12;
    localparam int INIT_TIMEOUT = 4000;
    localparam int REQ_TIMEOUT  = 2000;
    localparam int END_TIMEOUT  = 5000;

    logic                     hclk;
    logic                     nrst;
    logic                     req_valid_i;
    logic                     req_write_i;
    logic [`SDRAM_BA_W-1:0]   req_ba_i;
    logic [`SDRAM_ADDR_W-1:0] req_addr_i;
    logic                     req_ready_o;
    logic                     mem_cke_o;
    logic                     mem_cs_n_o;
    logic                     mem_ras_n_o;
    logic                     mem_cas_n_o;
    logic                     mem_we_n_o;
    logic [`SDRAM_BA_W-1:0]   mem_ba_o;
    logic [`SDRAM_ADDR_W-1:0] mem_addr_o;

    logic [31:0] lfsr_q;
    logic [3:0]  cmd;
    logic        load_mode_seen;
    int          refresh_cnt;
    int          req_pre_cnt;

    sdram_ctrl_top dut_i (.*);

    initial hclk = 1'b0;
    always #50 hclk = ~hclk;

    assign cmd = {mem_cs_n_o, mem_ras_n_o, mem_cas_n_o, mem_we_n_o};

    // Pin monitor; request PRECHARGEs keep A10 low
    always @(posedge hclk or negedge nrst)
    begin
        if (!nrst)
        begin
            load_mode_seen <= 1'b0;
            refresh_cnt    <= 0;
            req_pre_cnt    <= 0;
        end
        else
        begin
            if (cmd == CMD_LOAD_MODE)
                load_mode_seen <= 1'b1;
            if (load_mode_seen && cmd == CMD_REFRESH)
                refresh_cnt <= refresh_cnt + 1;
            if (load_mode_seen && cmd == CMD_PRECHARGE && !mem_addr_o[10])
                req_pre_cnt <= req_pre_cnt + 1;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[14:0], lfsr_q[0]};
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    initial
    begin
        logic [15:0] bits;
        int          waited;

        lfsr_q      = 32'hc6c1_94e4;
        nrst        = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_ba_i    = '0;
        req_addr_i  = '0;
        #10 nrst = 1'b0;                // Asynchronous assert, ahead of the first clock edge
        repeat (4) @(posedge hclk);
        nrst <= 1'b1;

        waited = 0;
        while (!load_mode_seen)
        begin
            @(negedge hclk);
            waited++;
            if (waited > INIT_TIMEOUT)
                stop_on_timeout("the first LOAD_MODE");
        end

        for (int r = 0; r < NUM_REQ; r++)
        begin
            take_bits(1, bits);
            if (bits[0])                // Idle cycle before this request
            begin
                @(posedge hclk);
                req_valid_i <= 1'b0;
            end
            @(posedge hclk);
            take_bits(1, bits);
            req_write_i <= bits[0];
            take_bits(`SDRAM_BA_W, bits);
            req_ba_i    <= bits[`SDRAM_BA_W-1:0];
            take_bits(`SDRAM_ADDR_W, bits);
            req_addr_i  <= bits[`SDRAM_ADDR_W-1:0];
            req_valid_i <= 1'b1;
            waited = 0;
            do
            begin
                @(negedge hclk);
                waited++;
                if (waited > REQ_TIMEOUT)
                    stop_on_timeout("a credit to accept a request");
            end
            while (!req_ready_o);
        end
        @(posedge hclk);
        req_valid_i <= 1'b0;

        waited = 0;
        while (refresh_cnt < 2 || req_pre_cnt < NUM_REQ)
        begin
            @(negedge hclk);
            waited++;
            if (waited > END_TIMEOUT)
                stop_on_timeout("the refreshes and request PRECHARGEs");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
